/* src/hsk_port_pkg.sv */
package hsk_port_pkg;

    // data path widths
    localparam int PORT_W     = 8;
    localparam int TEMP_W     = 12;
    localparam int BUF_ADDR_W = 8;

    // i2c line positions in the out_port and in_port bytes
    localparam int SCL_BIT = 1;
    localparam int SDA_BIT = 0;

    // upper bits of the board id byte
    localparam logic [2:0] ID_PREFIX = 3'b010;

    // decode masks, only bits 7 and 4:0 take part in any decode
    localparam logic [7:0] MASK_BASE    = 8'b1001_1111;
    // scl matches 0x0d and 0x0f
    localparam logic [7:0] MASK_SCL     = 8'b1001_1101;
    // sda matches 0x0e and 0x0f
    localparam logic [7:0] MASK_SDA     = 8'b1001_1110;
    // tx data on 0x08/0x09, control on 0x0a/0x0b
    localparam logic [7:0] MASK_UART_TX = 8'b1001_1110;
    // rx data on 0x08/0x0a, status on 0x09/0x0b
    localparam logic [7:0] MASK_UART_RX = 8'b1001_1101;
    localparam logic [7:0] MASK_ID      = 8'b1001_0001;

    typedef enum logic [7:0] {
        PORT_UART    = 8'h08,
        PORT_CTLSTAT = 8'h0B,
        PORT_I2C_IN  = 8'h0C,
        PORT_SCL     = 8'h0D,
        PORT_SDA     = 8'h0E,
        PORT_ID      = 8'h10,
        PORT_GEN_CTL = 8'h11
    } port_addr_e;

    // temperature low byte shares its address with the sda port (read vs write)
    localparam port_addr_e PORT_TEMP = PORT_SDA;

    // softcore port bus, bank is the active register bank
    typedef struct packed {
        logic [7:0] port_id;
        logic [7:0] out_port;
        logic       write_strobe;
        logic       k_write_strobe;
        logic       read_strobe;
        logic       bank;
    } pb_bus_t;

    typedef struct packed {
        logic buf_wr;
        logic tx_wr;
        logic ctl_wr;
        logic scl_wr;
        logic sda_wr;
        logic gc_wr;
        logic rx_rd;
        logic temp_rd;
    } port_sel_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
        logic       err;
    } cobs_rx_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_tx_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [11:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // hsk_enable_actual carries the registered crate bridge input state
    typedef struct packed {
        logic hsk_buf_sel;
        logic cratebridge_en;
        logic hsk_enable_actual;
    } gen_ctl_t;

endpackage

/* src/hsk_port_decode.sv */
`timescale 1ns/1ps

module hsk_port_decode (
    input  hsk_port_pkg::pb_bus_t   pb_i,
    output hsk_port_pkg::port_sel_t sel_o,
    output logic [7:0]              kport_id_o
);
    import hsk_port_pkg::*;

    logic any_wr;

    // k-port writes only carry 4 id bits
    // bit 7 gets the inverse of bit 3 so 0x0-0x7 land in the buffer at 0x80
    // and 0x8-0xf keep their register addresses
    assign kport_id_o = pb_i.k_write_strobe ?
                        {~pb_i.port_id[3], 3'b000, pb_i.port_id[3:0]} : pb_i.port_id;

    assign any_wr = pb_i.write_strobe | pb_i.k_write_strobe;

    always_comb begin
        // write selects use the remapped id
        sel_o.buf_wr = any_wr && kport_id_o[7];
        sel_o.tx_wr  = any_wr &&
                       ((kport_id_o & MASK_UART_TX) == (PORT_UART & MASK_UART_TX));
        sel_o.ctl_wr = any_wr &&
                       ((kport_id_o & MASK_UART_TX) == (PORT_CTLSTAT & MASK_UART_TX));
        sel_o.scl_wr = any_wr && ((kport_id_o & MASK_SCL) == PORT_SCL);
        sel_o.sda_wr = any_wr && ((kport_id_o & MASK_SDA) == PORT_SDA);
        // general control only from a normal output instruction
        sel_o.gc_wr  = pb_i.write_strobe && ((pb_i.port_id & MASK_ID) == PORT_GEN_CTL);
        // read selects never see k-ports
        sel_o.rx_rd   = pb_i.read_strobe &&
                        ((pb_i.port_id & MASK_UART_RX) == (PORT_UART & MASK_UART_RX));
        sel_o.temp_rd = pb_i.read_strobe && ((pb_i.port_id & MASK_BASE) == PORT_TEMP);
    end

endmodule

/* src/hsk_ctrl_regs.sv */
`timescale 1ns/1ps

module hsk_ctrl_regs (
    input  logic                                wb_clk_i,
    input  logic                                processor_reset,
    input  hsk_port_pkg::pb_bus_t               pb_i,
    input  hsk_port_pkg::port_sel_t             sel_i,
    input  logic                                core_hold_i,
    input  logic                                cratebridge_en_i,
    input  logic [hsk_port_pkg::TEMP_W-1:0]     temp_i,
    output hsk_port_pkg::gen_ctl_t              gen_ctl_o,
    output logic                                scl_t_o,
    output logic                                sda_t_o,
    output logic                                uart_reset_o,
    output logic                                bank_a_o,
    output logic                                bank_b_o,
    output logic [3:0]                          temp_high_o
);
    import hsk_port_pkg::*;

    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            gen_ctl_o    <= '0;
            scl_t_o      <= 1'b1;
            sda_t_o      <= 1'b1;
            uart_reset_o <= 1'b1;
            bank_a_o     <= 1'b0;
            bank_b_o     <= 1'b0;
        end else begin
            // bit 0 picks the hsk buffer half, bit 6 drives the crate bridge
            if (sel_i.gc_wr) begin
                gen_ctl_o.hsk_buf_sel    <= pb_i.out_port[0];
                gen_ctl_o.cratebridge_en <= pb_i.out_port[6];
            end
            // one stage on the bridge input before it shows in any status
            gen_ctl_o.hsk_enable_actual <= cratebridge_en_i;

            // held softcore leaves both lines released
            if (core_hold_i) begin
                scl_t_o <= 1'b1;
                sda_t_o <= 1'b1;
            end else begin
                // 1 releases the line, 0 pulls it low
                if (sel_i.scl_wr) begin
                    scl_t_o <= pb_i.out_port[SCL_BIT];
                end
                if (sel_i.sda_wr) begin
                    sda_t_o <= pb_i.out_port[SDA_BIT];
                end
            end

            if (sel_i.ctl_wr) begin
                uart_reset_o <= pb_i.out_port[7];
                // each register bank owns its own packet buffer half
                if (pb_i.bank) begin
                    bank_b_o <= pb_i.out_port[1];
                end else begin
                    bank_a_o <= pb_i.out_port[1];
                end
            end
        end
    end

    // upper nibble frozen at the low byte read so both halves match
    always_ff @(posedge wb_clk_i) begin
        if (sel_i.temp_rd) begin
            temp_high_o <= temp_i[TEMP_W-1:PORT_W];
        end
    end

endmodule

/* src/hsk_tx_fifo.sv */
`timescale 1ns/1ps

module hsk_tx_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                            wb_clk_i,
    input  logic                            processor_reset,
    input  logic                            flush_i,
    input  logic                            push_i,
    input  logic [hsk_port_pkg::PORT_W-1:0] data_i,
    input  logic                            tx_ready_i,
    output hsk_port_pkg::uart_tx_t          tx_o
);
    import hsk_port_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // small enough for distributed ram
    logic [PORT_W-1:0] mem [FIFO_DEPTH];
    // extra msb tells full from empty
    logic [AW:0]       wr_ptr;
    logic [AW:0]       rd_ptr;
    logic              full;
    logic              empty;
    logic              do_push;
    logic              do_pop;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    // writes into a full fifo are lost
    assign do_push = push_i && !full;
    assign do_pop  = tx_ready_i && !empty;

    always_ff @(posedge wb_clk_i) begin
        if (processor_reset || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= data_i;
        end
    end

    // head word falls through, so valid follows the write by one cycle
    assign tx_o.valid = !empty;
    assign tx_o.data  = mem[rd_ptr[AW-1:0]];

endmodule

/* src/hsk_buffer_ram.sv */
`timescale 1ns/1ps

module hsk_buffer_ram (
    input  logic                            wb_clk_i,
    input  hsk_port_pkg::pb_bus_t           pb_i,
    input  logic [7:0]                      kport_id_i,
    input  logic                            buf_wr_i,
    input  logic                            bank_a_i,
    input  logic                            bank_b_i,
    input  logic                            hsk_buf_sel_i,
    output logic [hsk_port_pkg::PORT_W-1:0] rd_data_o
);
    import hsk_port_pkg::*;

    logic [PORT_W-1:0]     mem [2**BUF_ADDR_W];
    logic [BUF_ADDR_W-1:0] addr;
    logic                  packet_bit;
    logic                  hsk_bit;

    // packet region follows the bank of whichever register set is active
    assign packet_bit = pb_i.bank ? bank_b_i : bank_a_i;
    // hsk region is double buffered
    // writes fill the selected half while reads drain the other one
    assign hsk_bit    = buf_wr_i ? hsk_buf_sel_i : ~hsk_buf_sel_i;
    assign addr       = {kport_id_i[6], kport_id_i[6] ? hsk_bit : packet_bit, kport_id_i[5:0]};

    always_ff @(posedge wb_clk_i) begin
        if (buf_wr_i) begin
            mem[addr] <= pb_i.out_port;
        end
        rd_data_o <= mem[addr];
    end

endmodule

/* src/hsk_read_mux.sv */
`timescale 1ns/1ps

module hsk_read_mux (
    input  logic                            wb_clk_i,
    input  logic                            processor_reset,
    input  hsk_port_pkg::pb_bus_t           pb_i,
    input  logic [hsk_port_pkg::PORT_W-1:0] buf_data_i,
    input  hsk_port_pkg::cobs_rx_t          cobs_rx_i,
    input  logic                            rx_rd_i,
    input  logic                            scl_i,
    input  logic                            sda_i,
    input  logic [hsk_port_pkg::TEMP_W-1:0] temp_i,
    input  logic [3:0]                      temp_high_i,
    input  hsk_port_pkg::gen_ctl_t          gen_ctl_i,
    input  logic                            hsk_enable_i,
    input  logic [1:0]                      conf_i,
    output logic [hsk_port_pkg::PORT_W-1:0] in_port_o
);
    import hsk_port_pkg::*;

    logic [PORT_W-1:0] pins;
    logic [PORT_W-1:0] rd_next;
    logic [PORT_W-1:0] rd_q;
    logic              buf_hit;
    logic              buf_q;
    logic              cobs_last;
    logic              cobs_err;

    always_comb begin
        pins          = '0;
        pins[SCL_BIT] = scl_i;
        pins[SDA_BIT] = sda_i;
    end

    // 0x80-0xff and the k-port alias 0x00-0x07 read the buffer
    assign buf_hit = pb_i.port_id[7] || (pb_i.port_id[6:3] == 4'b0000);

    always_comb begin
        if ((pb_i.port_id & MASK_ID) == PORT_GEN_CTL) begin
            rd_next = {hsk_enable_i, gen_ctl_i.hsk_enable_actual, 5'b00000,
                       gen_ctl_i.hsk_buf_sel};
        end else if ((pb_i.port_id & MASK_ID) == PORT_ID) begin
            rd_next = {ID_PREFIX, conf_i, 3'b000};
        end else if ((pb_i.port_id & MASK_UART_RX) == (PORT_UART & MASK_UART_RX)) begin
            rd_next = cobs_rx_i.data;
        end else if ((pb_i.port_id & MASK_UART_RX) == (PORT_CTLSTAT & MASK_UART_RX)) begin
            rd_next = {6'b000000, cobs_last, cobs_err};
        end else if ((pb_i.port_id & MASK_SDA) == (PORT_I2C_IN & MASK_SDA)) begin
            rd_next = pins;
        end else if ((pb_i.port_id & MASK_BASE) == PORT_TEMP) begin
            rd_next = temp_i[PORT_W-1:0];
        end else begin
            // 0x0f, nibble latched by the last 0x0e read
            rd_next = {4'b0000, temp_high_i};
        end
    end

    // sampled in the first access cycle, held into the strobe cycle
    always_ff @(posedge wb_clk_i) begin
        rd_q  <= rd_next;
        buf_q <= buf_hit;
    end

    // ram output is already registered on the same edge
    assign in_port_o = buf_q ? buf_data_i : rd_q;

    // frame status of the byte popped most recently
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            cobs_last <= 1'b0;
            cobs_err  <= 1'b0;
        end else if (rx_rd_i && cobs_rx_i.valid) begin
            cobs_last <= cobs_rx_i.last;
            cobs_err  <= cobs_rx_i.err;
        end
    end

endmodule

/* src/hsk_wb_ctrl.sv */
`timescale 1ns/1ps

module hsk_wb_ctrl #(
    parameter int WB_ADDR_W = 12
) (
    input  logic                  wb_clk_i,
    input  logic                  processor_reset,
    input  hsk_port_pkg::wb_req_t wb_req_i,
    input  logic                  cratebridge_actual_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,
    output logic                  wb_rty_o,
    output logic                  core_hold_o
);

    logic ack;
    logic hit;

    // address bits above the decoded window must be zero
    assign hit = ((wb_req_i.adr >> WB_ADDR_W) == '0);

    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            ack         <= 1'b0;
            core_hold_o <= 1'b0;
        end else begin
            ack <= wb_req_i.cyc && wb_req_i.stb;
            // write lands in the acked cycle
            if (wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && ack && wb_req_i.sel[0] && hit) begin
                core_hold_o <= wb_req_i.dat[0];
            end
        end
    end

    assign wb_ack_o = ack && wb_req_i.cyc && wb_req_i.stb;
    assign wb_dat_o = {30'd0, cratebridge_actual_i, core_hold_o};
    assign wb_err_o = 1'b0;
    assign wb_rty_o = 1'b0;

endmodule

/* src/hsk_port_top.sv */
`timescale 1ns/1ps

module hsk_port_top #(
    parameter int FIFO_DEPTH = 64,
    parameter int WB_ADDR_W  = 12
) (
    input  logic                            wb_clk_i,
    input  logic                            processor_reset,
    input  hsk_port_pkg::pb_bus_t           pb_i,
    input  hsk_port_pkg::wb_req_t           wb_req_i,
    input  hsk_port_pkg::cobs_rx_t          cobs_rx_i,
    input  logic                            uart_tx_ready_i,
    input  logic                            scl_i,
    input  logic                            sda_i,
    input  logic [1:0]                      conf_i,
    input  logic [hsk_port_pkg::TEMP_W-1:0] temp_i,
    input  logic                            cratebridge_en_i,
    input  logic                            hsk_enable_i,
    output logic [hsk_port_pkg::PORT_W-1:0] in_port_o,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,
    output logic                            wb_rty_o,
    output logic                            core_hold_o,
    output logic                            cobs_rx_ready_o,
    output logic                            interrupt_o,
    output hsk_port_pkg::uart_tx_t          uart_tx_o,
    output logic                            uart_reset_o,
    output logic                            scl_t_o,
    output logic                            sda_t_o,
    output logic                            cratebridge_en_o,
    output logic                            hsk_enable_t_o,
    output logic                            hsk_enable_o
);
    import hsk_port_pkg::*;

    port_sel_t         sel;
    gen_ctl_t          gen_ctl;
    logic [7:0]        kport_id;
    logic [PORT_W-1:0] buf_data;
    logic              bank_a;
    logic              bank_b;
    logic [3:0]        temp_high;

    hsk_port_decode u_decode (
        .pb_i       (pb_i),
        .sel_o      (sel),
        .kport_id_o (kport_id)
    );

    hsk_ctrl_regs u_ctrl (
        .wb_clk_i         (wb_clk_i),
        .processor_reset  (processor_reset),
        .pb_i             (pb_i),
        .sel_i            (sel),
        .core_hold_i      (core_hold_o),
        .cratebridge_en_i (cratebridge_en_i),
        .temp_i           (temp_i),
        .gen_ctl_o        (gen_ctl),
        .scl_t_o          (scl_t_o),
        .sda_t_o          (sda_t_o),
        .uart_reset_o     (uart_reset_o),
        .bank_a_o         (bank_a),
        .bank_b_o         (bank_b),
        .temp_high_o      (temp_high)
    );

    // uart reset also empties the transmit queue
    hsk_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .wb_clk_i        (wb_clk_i),
        .processor_reset (processor_reset),
        .flush_i         (uart_reset_o),
        .push_i          (sel.tx_wr),
        .data_i          (pb_i.out_port),
        .tx_ready_i      (uart_tx_ready_i),
        .tx_o            (uart_tx_o)
    );

    hsk_buffer_ram u_buf (
        .wb_clk_i      (wb_clk_i),
        .pb_i          (pb_i),
        .kport_id_i    (kport_id),
        .buf_wr_i      (sel.buf_wr),
        .bank_a_i      (bank_a),
        .bank_b_i      (bank_b),
        .hsk_buf_sel_i (gen_ctl.hsk_buf_sel),
        .rd_data_o     (buf_data)
    );

    hsk_read_mux u_rd_mux (
        .wb_clk_i        (wb_clk_i),
        .processor_reset (processor_reset),
        .pb_i            (pb_i),
        .buf_data_i      (buf_data),
        .cobs_rx_i       (cobs_rx_i),
        .rx_rd_i         (sel.rx_rd),
        .scl_i           (scl_i),
        .sda_i           (sda_i),
        .temp_i          (temp_i),
        .temp_high_i     (temp_high),
        .gen_ctl_i       (gen_ctl),
        .hsk_enable_i    (hsk_enable_i),
        .conf_i          (conf_i),
        .in_port_o       (in_port_o)
    );

    hsk_wb_ctrl #(.WB_ADDR_W(WB_ADDR_W)) u_wb (
        .wb_clk_i             (wb_clk_i),
        .processor_reset      (processor_reset),
        .wb_req_i             (wb_req_i),
        .cratebridge_actual_i (gen_ctl.hsk_enable_actual),
        .wb_dat_o             (wb_dat_o),
        .wb_ack_o             (wb_ack_o),
        .wb_err_o             (wb_err_o),
        .wb_rty_o             (wb_rty_o),
        .core_hold_o          (core_hold_o)
    );

    // rx pops in the strobe cycle, interrupt whenever a byte waits
    assign cobs_rx_ready_o  = sel.rx_rd;
    assign interrupt_o      = cobs_rx_i.valid;
    assign cratebridge_en_o = gen_ctl.cratebridge_en;
    // enable pin is only driven during the general control write
    assign hsk_enable_t_o   = ~sel.gc_wr;
    assign hsk_enable_o     = pb_i.out_port[7];

endmodule

/* tests/hsk_port_model.svh */
`ifndef HSK_PORT_MODEL_SVH
`define HSK_PORT_MODEL_SVH

// model copies of the dut registers
logic       m_scl;
logic       m_sda;
logic       m_uart_rst;
logic       m_bank_a;
logic       m_bank_b;
logic       m_buf_sel;
logic       m_cb_en;
logic       m_cb_act;
logic       m_hold;
logic       m_ack;
logic       m_last;
logic       m_err;
logic [3:0] m_temp_high;
logic       m_temp_ok;
logic [7:0] m_mem [256];
// buffer locations written since start, others read back unknown
logic       m_mem_ok [256];
logic [7:0] m_fifo [$];

// k-port ids carry only four bits
function automatic logic [7:0] eff_id(input pb_bus_t b);
    if (b.k_write_strobe) begin
        return {~b.port_id[3], 3'b000, b.port_id[3:0]};
    end
    return b.port_id;
endfunction

function automatic logic [7:0] buf_addr(input logic [7:0] id, input logic bank,
                                        input logic wr);
    logic half;
    if (id[6]) begin
        // hsk half is double buffered
        half = wr ? m_buf_sel : ~m_buf_sel;
    end else begin
        half = bank ? m_bank_b : m_bank_a;
    end
    return {id[6], half, id[5:0]};
endfunction

// value in_port should show for a read of id, from the current state
function automatic logic [7:0] read_expect(input logic [7:0] id, output logic known);
    logic [7:0] a;
    known = 1'b1;
    if (id[7] || (id[6:3] == 4'b0000)) begin
        a = buf_addr(id, pb.bank, 1'b0);
        known = m_mem_ok[a];
        return m_mem[a];
    end
    case (id)
        8'h08, 8'h0A: return cobs.data;
        8'h09, 8'h0B: return {6'b000000, m_last, m_err};
        8'h0C, 8'h0D: return {6'b000000, scl_in, sda_in};
        8'h0E: return temp[7:0];
        8'h0F: begin
            known = m_temp_ok;
            return {4'b0000, m_temp_high};
        end
        8'h10: return {3'b010, conf, 3'b000};
        8'h11: return {hsk_en, m_cb_act, 5'b00000, m_buf_sel};
        default: begin
            known = 1'b0;
            return 8'h00;
        end
    endcase
endfunction

// advance the model by one clock edge, all side effects use the old state
task automatic model_step();
    logic [7:0] id;
    logic       wr;
    logic       full;
    id = eff_id(pb);
    wr = pb.write_strobe | pb.k_write_strobe;
    if (processor_reset) begin
        m_scl      = 1'b1;
        m_sda      = 1'b1;
        m_uart_rst = 1'b1;
        m_bank_a   = 1'b0;
        m_bank_b   = 1'b0;
        m_buf_sel  = 1'b0;
        m_cb_en    = 1'b0;
        m_cb_act   = 1'b0;
        m_hold     = 1'b0;
        m_ack      = 1'b0;
        m_last     = 1'b0;
        m_err      = 1'b0;
        m_fifo.delete();
        return;
    end
    // fifo full is judged before this edge's pop
    full = (m_fifo.size() == FIFO_DEPTH);
    if (m_uart_rst) begin
        m_fifo.delete();
    end else begin
        if (uart_tx_ready && (m_fifo.size() > 0)) begin
            void'(m_fifo.pop_front());
        end
        if (wr && ((id == 8'h08) || (id == 8'h09)) && !full) begin
            m_fifo.push_back(pb.out_port);
        end
    end
    if (wr && id[7]) begin
        m_mem[buf_addr(id, pb.bank, 1'b1)]    = pb.out_port;
        m_mem_ok[buf_addr(id, pb.bank, 1'b1)] = 1'b1;
    end
    if (m_hold) begin
        m_scl = 1'b1;
        m_sda = 1'b1;
    end else begin
        if (wr && ((id == 8'h0D) || (id == 8'h0F))) begin
            m_scl = pb.out_port[1];
        end
        if (wr && ((id == 8'h0E) || (id == 8'h0F))) begin
            m_sda = pb.out_port[0];
        end
    end
    if (wr && ((id == 8'h0A) || (id == 8'h0B))) begin
        m_uart_rst = pb.out_port[7];
        if (pb.bank) begin
            m_bank_b = pb.out_port[1];
        end else begin
            m_bank_a = pb.out_port[1];
        end
    end
    if (pb.write_strobe && (pb.port_id == 8'h11)) begin
        m_buf_sel = pb.out_port[0];
        m_cb_en   = pb.out_port[6];
    end
    m_cb_act = cb_en;
    if (pb.read_strobe && (pb.port_id == 8'h0E)) begin
        m_temp_high = temp[11:8];
        m_temp_ok   = 1'b1;
    end
    if (pb.read_strobe && ((pb.port_id == 8'h08) || (pb.port_id == 8'h0A)) && cobs.valid) begin
        m_last = cobs.last;
        m_err  = cobs.err;
    end
    if (wb.cyc && wb.stb && wb.we && m_ack && wb.sel[0]) begin
        m_hold = wb.dat[0];
    end
    m_ack = wb.cyc && wb.stb;
endtask

`endif

/* tests/hsk_port_tb.sv */
`timescale 1ns/1ps

module hsk_port_tb;
    import hsk_port_pkg::*;

    localparam int FIFO_DEPTH = 64;
    localparam int N_OPS      = 400;
    localparam int BURST_LEN  = 80;
    localparam int N_BURST    = 3;
    // every op takes at most 4 cycles, plus reset and a full fifo drain
    localparam int LIMIT = (N_OPS + N_BURST * (BURST_LEN + 2)) * 4 + FIFO_DEPTH + 200;

    logic        wb_clk_i;
    logic        processor_reset;
    pb_bus_t     pb;
    wb_req_t     wb;
    cobs_rx_t    cobs;
    logic        uart_tx_ready;
    logic        scl_in;
    logic        sda_in;
    logic [1:0]  conf;
    logic [11:0] temp;
    logic        cb_en;
    logic        hsk_en;

    logic [7:0]  in_port;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic        wb_err;
    logic        wb_rty;
    logic        core_hold;
    logic        cobs_ready;
    logic        irq;
    uart_tx_t    uart_tx;
    logic        uart_reset;
    logic        scl_t;
    logic        sda_t;
    logic        cb_en_out;
    logic        hsk_en_t;
    logic        hsk_en_out;

    integer      seed;
    int          cycles;
    int          errors;
    logic        hold_ready;
    logic        drain;
    logic [7:0]  exp_rd;
    logic        exp_rd_chk;

    `include "hsk_port_model.svh"

    hsk_port_top #(.FIFO_DEPTH(FIFO_DEPTH), .WB_ADDR_W(12)) dut_i (
        .wb_clk_i         (wb_clk_i),
        .processor_reset  (processor_reset),
        .pb_i             (pb),
        .wb_req_i         (wb),
        .cobs_rx_i        (cobs),
        .uart_tx_ready_i  (uart_tx_ready),
        .scl_i            (scl_in),
        .sda_i            (sda_in),
        .conf_i           (conf),
        .temp_i           (temp),
        .cratebridge_en_i (cb_en),
        .hsk_enable_i     (hsk_en),
        .in_port_o        (in_port),
        .wb_dat_o         (wb_dat),
        .wb_ack_o         (wb_ack),
        .wb_err_o         (wb_err),
        .wb_rty_o         (wb_rty),
        .core_hold_o      (core_hold),
        .cobs_rx_ready_o  (cobs_ready),
        .interrupt_o      (irq),
        .uart_tx_o        (uart_tx),
        .uart_reset_o     (uart_reset),
        .scl_t_o          (scl_t),
        .sda_t_o          (sda_t),
        .cratebridge_en_o (cb_en_out),
        .hsk_enable_t_o   (hsk_en_t),
        .hsk_enable_o     (hsk_en_out)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #10 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge wb_clk_i) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout, the test sequence did not finish within %0d cycles", LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] rnd32();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic [7:0] rnd8();
        logic [31:0] r;
        r = rnd32();
        return r[7:0];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // new pin, sensor and rx stream values, held for a whole op
    task automatic new_inputs();
        logic [31:0] r;
        r          = rnd32();
        scl_in     = r[0];
        sda_in     = r[1];
        conf       = r[3:2];
        cb_en      = r[4];
        hsk_en     = r[5];
        temp       = r[17:6];
        cobs.valid = r[18] | r[19];
        cobs.last  = r[20];
        cobs.err   = r[21];
        cobs.data  = r[29:22];
    endtask

    // one clock, entered and left just after a falling edge
    task automatic cycle();
        logic [31:0] r;
        logic [7:0]  id;
        r = rnd32();
        uart_tx_ready = drain ? 1'b1 : (hold_ready ? 1'b0 : r[0]);
        id = pb.port_id;
        #2;
        if (!processor_reset) begin
            check("scl_t_o", 32'(scl_t), 32'(m_scl));
            check("sda_t_o", 32'(sda_t), 32'(m_sda));
            check("uart_reset_o", 32'(uart_reset), 32'(m_uart_rst));
            check("core_hold_o", 32'(core_hold), 32'(m_hold));
            check("cratebridge_en_o", 32'(cb_en_out), 32'(m_cb_en));
            check("wb_dat_o", wb_dat, {30'd0, m_cb_act, m_hold});
            check("wb_ack_o", 32'(wb_ack), 32'(m_ack && wb.cyc && wb.stb));
            check("wb_err_o", 32'(wb_err), 32'd0);
            check("wb_rty_o", 32'(wb_rty), 32'd0);
            check("hsk_enable_t_o", 32'(hsk_en_t), 32'(!(pb.write_strobe && (id == 8'h11))));
            check("hsk_enable_o", 32'(hsk_en_out), 32'(pb.out_port[7]));
            check("cobs_rx_ready_o", 32'(cobs_ready),
                  32'(pb.read_strobe && ((id == 8'h08) || (id == 8'h0A))));
            check("interrupt_o", 32'(irq), 32'(cobs.valid));
            check("uart_tx_o.valid", 32'(uart_tx.valid), 32'(m_fifo.size() > 0));
            if (m_fifo.size() > 0) begin
                check("uart_tx_o.data", 32'(uart_tx.data), 32'(m_fifo[0]));
            end
            if (pb.read_strobe && exp_rd_chk) begin
                check("in_port_o", 32'(in_port), 32'(exp_rd));
            end
        end
        @(posedge wb_clk_i);
        model_step();
        @(negedge wb_clk_i);
    endtask

    task automatic port_write(input logic [7:0] id, input logic [7:0] data, input logic k);
        pb.port_id        = id;
        pb.out_port       = data;
        pb.write_strobe   = !k;
        pb.k_write_strobe = k;
        cycle();
        pb.write_strobe   = 1'b0;
        pb.k_write_strobe = 1'b0;
    endtask

    // address cycle, then the strobe cycle in which in_port is compared
    task automatic port_read(input logic [7:0] id);
        pb.port_id = id;
        exp_rd = read_expect(id, exp_rd_chk);
        cycle();
        pb.read_strobe = 1'b1;
        cycle();
        pb.read_strobe = 1'b0;
        exp_rd_chk     = 1'b0;
    endtask

    task automatic wb_access(input logic we);
        logic [31:0] r;
        r      = rnd32();
        wb.cyc = 1'b1;
        wb.stb = 1'b1;
        wb.we  = we;
        wb.sel = r[3:0];
        wb.adr = r[15:4];
        wb.dat = rnd32();
        // request cycle, then the acked cycle
        cycle();
        cycle();
        wb.cyc = 1'b0;
        wb.stb = 1'b0;
        cycle();
    endtask

    task automatic tx_burst();
        int i;
        port_write(8'h0B, 8'h00, 1'b0);
        hold_ready = 1'b1;
        for (i = 0; i < BURST_LEN; i++) begin
            port_write(8'h08 + {7'd0, rnd8() > 8'd127}, rnd8(), rnd8() > 8'd200);
        end
        hold_ready = 1'b0;
    endtask

    task automatic run_op(input logic [7:0] op);
        logic [7:0] d;
        d = rnd8();
        new_inputs();
        case (op)
            8'd0: wb_access(1'b1);
            8'd1: wb_access(1'b0);
            // scl on 0x0d, sda on 0x0e, both on 0x0f
            8'd2: port_write(8'h0D + (rnd8() % 8'd3), d, d[7]);
            8'd3: port_read(8'h0C + {7'd0, d[0]});
            8'd4: begin
                port_write(8'h11, d, 1'b0);
                port_read(8'h10 + {7'd0, rnd8() > 8'd127});
            end
            8'd5: port_write(8'h08 + {7'd0, d[0]}, rnd8(), d[1]);
            8'd6: begin
                pb.bank = d[0];
                // uart reset only now and then so the fifo fills
                port_write(8'h0A + {7'd0, d[2]}, {rnd8() < 8'd30, 7'(rnd8())},
                           d[3]);
            end
            8'd7: begin
                port_read(8'h08);
                port_read(8'h09);
            end
            8'd8: begin
                port_read(8'h0E);
                temp = 12'(rnd32());
                port_read(8'h0F);
            end
            8'd9: begin
                pb.bank = d[0];
                if (d[1]) begin
                    port_write({1'b1, 7'(rnd8())}, rnd8(), 1'b0);
                end else begin
                    port_write(rnd8() % 8'd8, rnd8(), 1'b1);
                end
            end
            default: begin
                pb.bank = d[0];
                if (d[1]) begin
                    port_read({1'b1, 7'(rnd8())});
                end else begin
                    port_read(rnd8() % 8'd8);
                end
            end
        endcase
    endtask

    initial begin
        int i;
        seed            = 98703;
        cycles          = 0;
        errors          = 0;
        hold_ready      = 1'b0;
        drain           = 1'b0;
        exp_rd          = 8'h00;
        exp_rd_chk      = 1'b0;
        processor_reset = 1'b1;
        pb              = '0;
        wb              = '0;
        cobs            = '0;
        uart_tx_ready   = 1'b0;
        scl_in          = 1'b1;
        sda_in          = 1'b1;
        conf            = 2'b00;
        temp            = 12'h000;
        cb_en           = 1'b0;
        hsk_en          = 1'b0;
        m_temp_ok       = 1'b0;
        m_temp_high     = 4'h0;
        for (i = 0; i < 256; i++) begin
            m_mem[i]    = 8'h00;
            m_mem_ok[i] = 1'b0;
        end
        @(negedge wb_clk_i);
        repeat (5) cycle();
        processor_reset = 1'b0;
        // take the uart out of reset
        port_write(8'h0B, 8'h00, 1'b0);
        for (i = 0; i < N_OPS; i++) begin
            if ((i % 150) == 75) begin
                tx_burst();
            end
            run_op(rnd8() % 8'd11);
        end
        // empty the fifo with the uart running
        port_write(8'h0B, 8'h00, 1'b0);
        drain = 1'b1;
        while (m_fifo.size() > 0) begin
            cycle();
        end
        cycle();
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hsk_port_top.f */
+incdir+tests
src/hsk_port_pkg.sv
src/hsk_port_decode.sv
src/hsk_ctrl_regs.sv
src/hsk_tx_fifo.sv
src/hsk_buffer_ram.sv
src/hsk_read_mux.sv
src/hsk_wb_ctrl.sv
src/hsk_port_top.sv
tests/hsk_port_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --top-module hsk_port_tb -f hsk_port_top.f -o hsk_port_sim
./obj_dir/hsk_port_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    exit 1
fi
exit 0
